// ==== rtl/sensor_dma_pkg.sv ====
package sensor_dma_pkg;

    localparam int DATA_W = 32;  // One bus word
    localparam int ADDR_W = 10;  // Byte address

    // Host request that the host holds until the acknowledge
    typedef struct packed {
        logic [ADDR_W-3:0] adr;          // Word address
        logic              cyc_regs;     // Register bank
        logic              cyc_dma_reg;  // DMA register bank
        logic              cyc_dma_dat;  // FIFO data port
        logic              stb;
        logic              we;
        logic [3:0]        byte_stb;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    // Decoded register within the active bank
    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_DEV_ID,
        SEL_REV,
        SEL_FIFO_RST,
        SEL_SENSOR_EN,
        SEL_OVERRUN,
        SEL_DMA_EN,
        SEL_DMA_STS,
        SEL_DMA_IRQ_EN
    } reg_sel_e;

    // All writable registers are single-bit controls
    typedef struct packed {
        logic     wr_en;
        reg_sel_e sel;
        logic     dat0;
    } reg_wr_t;

    typedef struct packed {
        logic        sensor_en;
        logic        overrun;
        logic [15:0] overrun_cnt;
    } ctrl_status_t;

    typedef struct packed {
        logic dma_en;
        logic done;
        logic irq_en;
    } dma_status_t;

    // Register bank byte offsets
    localparam logic [ADDR_W-1:0] DEV_ID_OFS     = 10'h000;
    localparam logic [ADDR_W-1:0] REV_OFS        = 10'h004;
    localparam logic [ADDR_W-1:0] FIFO_RST_OFS   = 10'h008;
    localparam logic [ADDR_W-1:0] SENSOR_EN_OFS  = 10'h00C;
    localparam logic [ADDR_W-1:0] OVERRUN_OFS    = 10'h010;

    // DMA register bank byte offsets
    localparam logic [ADDR_W-1:0] DMA_EN_OFS     = 10'h000;
    localparam logic [ADDR_W-1:0] DMA_STS_OFS    = 10'h004;
    localparam logic [ADDR_W-1:0] DMA_IRQ_EN_OFS = 10'h008;

    localparam logic [DATA_W-1:0] DEVICE_ID      = 32'h0ADC0001;
    localparam logic [DATA_W-1:0] REV_NUM        = 32'h00000100;
    localparam logic [DATA_W-1:0] DEFAULT_READ   = 32'hFABDEFAC;  // Unmapped addresses

endpackage

// ==== rtl/wb_reg_decode.sv ====
`timescale 1ns/1ps
module wb_reg_decode (
    input  logic                                WBs_CLK_i,
    input  logic                                FIFO_Flush,
    input  sensor_dma_pkg::wb_req_t             req_i,
    input  sensor_dma_pkg::ctrl_status_t        ctrl_sts_i,
    input  sensor_dma_pkg::dma_status_t         dma_sts_i,
    output logic                                ack_o,
    output sensor_dma_pkg::reg_wr_t             reg_wr_o,
    output logic                                pop_o,
    output logic [sensor_dma_pkg::DATA_W-1:0]   reg_rd_o,
    output logic [sensor_dma_pkg::DATA_W-1:0]   dma_reg_rd_o
);

    localparam int AW = sensor_dma_pkg::ADDR_W;
    localparam int DW = sensor_dma_pkg::DATA_W;

    logic                     ack_nxt;
    logic                     any_cyc;
    sensor_dma_pkg::reg_sel_e sel;

    assign any_cyc = req_i.cyc_regs | req_i.cyc_dma_reg | req_i.cyc_dma_dat;
    assign ack_nxt = any_cyc & req_i.stb & ~ack_o;  // New request only

    always_ff @(posedge WBs_CLK_i or posedge FIFO_Flush)
    begin
        if (FIFO_Flush)
        begin
            ack_o <= 1'b0;
            pop_o <= 1'b0;
        end
        else
        begin
            ack_o <= ack_nxt;
            // Head word stays visible through the ack cycle and leaves at its end
            pop_o <= ack_nxt & req_i.cyc_dma_dat & ~req_i.we;
        end
    end

    // Word address decode within the selected bank
    always_comb
    begin
        sel = sensor_dma_pkg::SEL_NONE;
        if (req_i.cyc_regs)
        begin
            if (req_i.adr == sensor_dma_pkg::DEV_ID_OFS[AW-1:2])
                sel = sensor_dma_pkg::SEL_DEV_ID;
            else if (req_i.adr == sensor_dma_pkg::REV_OFS[AW-1:2])
                sel = sensor_dma_pkg::SEL_REV;
            else if (req_i.adr == sensor_dma_pkg::FIFO_RST_OFS[AW-1:2])
                sel = sensor_dma_pkg::SEL_FIFO_RST;
            else if (req_i.adr == sensor_dma_pkg::SENSOR_EN_OFS[AW-1:2])
                sel = sensor_dma_pkg::SEL_SENSOR_EN;
            else if (req_i.adr == sensor_dma_pkg::OVERRUN_OFS[AW-1:2])
                sel = sensor_dma_pkg::SEL_OVERRUN;
        end
        else if (req_i.cyc_dma_reg)
        begin
            if (req_i.adr == sensor_dma_pkg::DMA_EN_OFS[AW-1:2])
                sel = sensor_dma_pkg::SEL_DMA_EN;
            else if (req_i.adr == sensor_dma_pkg::DMA_STS_OFS[AW-1:2])
                sel = sensor_dma_pkg::SEL_DMA_STS;
            else if (req_i.adr == sensor_dma_pkg::DMA_IRQ_EN_OFS[AW-1:2])
                sel = sensor_dma_pkg::SEL_DMA_IRQ_EN;
        end
    end

    // Writes land on the edge that raises ack and need byte lane 0
    assign reg_wr_o.wr_en = ack_nxt & req_i.we & req_i.byte_stb[0]
                          & (sel != sensor_dma_pkg::SEL_NONE);
    assign reg_wr_o.sel   = sel;
    assign reg_wr_o.dat0  = req_i.dat[0];

    always_comb
    begin
        case (sel)
            sensor_dma_pkg::SEL_DEV_ID:    reg_rd_o = sensor_dma_pkg::DEVICE_ID;
            sensor_dma_pkg::SEL_REV:       reg_rd_o = sensor_dma_pkg::REV_NUM;
            sensor_dma_pkg::SEL_FIFO_RST:  reg_rd_o = '0;  // Self-clearing
            sensor_dma_pkg::SEL_SENSOR_EN: reg_rd_o = {{(DW-1){1'b0}}, ctrl_sts_i.sensor_en};
            sensor_dma_pkg::SEL_OVERRUN:
                reg_rd_o = {ctrl_sts_i.overrun_cnt, {(DW-17){1'b0}}, ctrl_sts_i.overrun};
            default:                       reg_rd_o = sensor_dma_pkg::DEFAULT_READ;
        endcase
    end

    always_comb
    begin
        case (sel)
            sensor_dma_pkg::SEL_DMA_EN:     dma_reg_rd_o = {{(DW-1){1'b0}}, dma_sts_i.dma_en};
            sensor_dma_pkg::SEL_DMA_STS:    dma_reg_rd_o = {{(DW-1){1'b0}}, dma_sts_i.done};
            sensor_dma_pkg::SEL_DMA_IRQ_EN: dma_reg_rd_o = {{(DW-1){1'b0}}, dma_sts_i.irq_en};
            default:                        dma_reg_rd_o = sensor_dma_pkg::DEFAULT_READ;
        endcase
    end

endmodule

// ==== rtl/sensor_ctrl_regs.sv ====
`timescale 1ns/1ps
module sensor_ctrl_regs (
    input  logic                         WBs_CLK_i,
    input  logic                         FIFO_Flush,
    input  sensor_dma_pkg::reg_wr_t      reg_wr_i,
    input  logic                         overrun_i,
    output logic                         sensor_en_o,
    output logic                         flush_o,
    output sensor_dma_pkg::ctrl_status_t sts_o
);

    logic        sensor_en_wr;
    logic        fifo_rst_wr;
    logic        overrun_q;
    logic [15:0] overrun_cnt_q;

    assign sensor_en_wr = reg_wr_i.wr_en & (reg_wr_i.sel == sensor_dma_pkg::SEL_SENSOR_EN);
    assign fifo_rst_wr  = reg_wr_i.wr_en & (reg_wr_i.sel == sensor_dma_pkg::SEL_FIFO_RST);

    always_ff @(posedge WBs_CLK_i or posedge FIFO_Flush)
    begin
        if (FIFO_Flush)
        begin
            sensor_en_o <= 1'b0;
            flush_o     <= 1'b0;
        end
        else
        begin
            if (sensor_en_wr)
                sensor_en_o <= reg_wr_i.dat0;
            flush_o <= fifo_rst_wr & reg_wr_i.dat0;  // One-cycle pulse
        end
    end

    // Sticky flag and wrapping count of dropped pushes
    always_ff @(posedge WBs_CLK_i or posedge FIFO_Flush)
    begin
        if (FIFO_Flush)
        begin
            overrun_q     <= 1'b0;
            overrun_cnt_q <= '0;
        end
        else if (flush_o)
        begin
            overrun_q     <= 1'b0;
            overrun_cnt_q <= '0;
        end
        else if (overrun_i)
        begin
            overrun_q     <= 1'b1;
            overrun_cnt_q <= overrun_cnt_q + 16'd1;
        end
    end

    assign sts_o.sensor_en   = sensor_en_o;
    assign sts_o.overrun     = overrun_q;
    assign sts_o.overrun_cnt = overrun_cnt_q;

endmodule

// ==== rtl/dma_ctrl_regs.sv ====
`timescale 1ns/1ps
module dma_ctrl_regs #(
    parameter int LEVEL_W         = 10,
    parameter int DMA_START_LEVEL = 255
) (
    input  logic                        WBs_CLK_i,
    input  logic                        FIFO_Flush,
    input  sensor_dma_pkg::reg_wr_t     reg_wr_i,
    input  logic                        dma_done_i,
    input  logic                        dma_clr_i,
    input  logic [LEVEL_W-1:0]          level_i,
    output logic                        dma_en_o,
    output logic                        dma_start_o,
    output logic                        dma_irq_o,
    output sensor_dma_pkg::dma_status_t sts_o
);

    logic en_wr;
    logic sts_wr;
    logic irq_en_wr;
    logic done_q;
    logic irq_en_q;

    assign en_wr     = reg_wr_i.wr_en & (reg_wr_i.sel == sensor_dma_pkg::SEL_DMA_EN);
    assign sts_wr    = reg_wr_i.wr_en & (reg_wr_i.sel == sensor_dma_pkg::SEL_DMA_STS);
    assign irq_en_wr = reg_wr_i.wr_en & (reg_wr_i.sel == sensor_dma_pkg::SEL_DMA_IRQ_EN);

    always_ff @(posedge WBs_CLK_i or posedge FIFO_Flush)
    begin
        if (FIFO_Flush)
        begin
            dma_en_o <= 1'b0;
            done_q   <= 1'b0;
            irq_en_q <= 1'b0;
        end
        else
        begin
            // Software write beats the clear input
            if (en_wr)
                dma_en_o <= reg_wr_i.dat0;
            else if (dma_clr_i)
                dma_en_o <= 1'b0;

            // Done from the DMA engine beats a status write
            if (dma_done_i)
                done_q <= 1'b1;
            else if (sts_wr)
                done_q <= reg_wr_i.dat0;

            if (irq_en_wr)
                irq_en_q <= reg_wr_i.dat0;
        end
    end

    // Start once enough words are buffered
    assign dma_start_o = (level_i > LEVEL_W'(DMA_START_LEVEL)) & dma_en_o;
    assign dma_irq_o   = done_q & irq_en_q;

    assign sts_o.dma_en = dma_en_o;
    assign sts_o.done   = done_q;
    assign sts_o.irq_en = irq_en_q;

endmodule

// ==== rtl/sensor_fifo.sv ====
`timescale 1ns/1ps
module sensor_fifo #(
    parameter int FIFO_DEPTH = 512,  // Power of two
    parameter int LEVEL_W    = 10
) (
    input  logic                              WBs_CLK_i,
    input  logic                              FIFO_Flush,
    input  logic                              flush_i,
    input  logic                              push_i,
    input  logic [sensor_dma_pkg::DATA_W-1:0] push_data_i,
    input  logic                              pop_i,
    output logic [sensor_dma_pkg::DATA_W-1:0] pop_data_o,
    output logic [LEVEL_W-1:0]                level_o,
    output logic                              full_o,
    output logic                              overrun_o
);

    localparam int PTR_W = LEVEL_W - 1;  // Pointers wrap at FIFO_DEPTH

    logic [sensor_dma_pkg::DATA_W-1:0] mem [FIFO_DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [LEVEL_W-1:0] level_q;
    logic               empty;
    logic               push_ok;
    logic               pop_ok;

    assign full_o  = (level_q == LEVEL_W'(FIFO_DEPTH));
    assign empty   = (level_q == '0);
    assign push_ok = push_i & ~full_o;
    assign pop_ok  = pop_i & ~empty;

    // Push while full is lost
    assign overrun_o = push_i & full_o;

    // Word storage
    always_ff @(posedge WBs_CLK_i)
    begin
        if (push_ok)
            mem[wr_ptr] <= push_data_i;
    end

    always_ff @(posedge WBs_CLK_i or posedge FIFO_Flush)
    begin
        if (FIFO_Flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else if (flush_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= wr_ptr + PTR_W'(1);
            if (pop_ok)
                rd_ptr <= rd_ptr + PTR_W'(1);
        end
    end

    always_ff @(posedge WBs_CLK_i or posedge FIFO_Flush)
    begin
        if (FIFO_Flush)
            level_q <= '0;
        else if (flush_i)
            level_q <= '0;
        else if (push_ok && !pop_ok)
            level_q <= level_q + LEVEL_W'(1);
        else if (pop_ok && !push_ok)
            level_q <= level_q - LEVEL_W'(1);
    end

    assign pop_data_o = mem[rd_ptr];  // Head word read without latency
    assign level_o    = level_q;

endmodule

// ==== rtl/sensor_dma_top.sv ====
`timescale 1ns/1ps
module sensor_dma_top #(
    parameter int FIFO_DEPTH      = 512,
    parameter int DMA_START_LEVEL = 255   // Below FIFO_DEPTH
) (
    input  logic                              WBs_CLK_i,
    input  logic                              FIFO_Flush,
    input  sensor_dma_pkg::wb_req_t           req_i,
    output logic                              ack_o,
    output logic [sensor_dma_pkg::DATA_W-1:0] reg_rd_o,
    output logic [sensor_dma_pkg::DATA_W-1:0] dma_reg_rd_o,
    output logic [sensor_dma_pkg::DATA_W-1:0] dma_dat_o,
    input  logic [sensor_dma_pkg::DATA_W-1:0] sensor_data_i,
    input  logic                              sensor_push_i,
    input  logic                              dma_done_i,
    input  logic                              dma_clr_i,
    output logic                              sensor_en_o,
    output logic                              fifo_full_o,
    output logic                              dma_en_o,
    output logic                              dma_start_o,
    output logic                              dma_irq_o,
    output logic [sensor_dma_pkg::DATA_W-1:0] device_id_o
);

    localparam int LEVEL_W = $clog2(FIFO_DEPTH) + 1;  // Holds FIFO_DEPTH itself

    sensor_dma_pkg::reg_wr_t      reg_wr;
    sensor_dma_pkg::ctrl_status_t ctrl_sts;
    sensor_dma_pkg::dma_status_t  dma_sts;
    logic                         pop;
    logic                         flush;
    logic                         overrun;
    logic [LEVEL_W-1:0]           level;

    assign device_id_o = sensor_dma_pkg::DEVICE_ID;

    wb_reg_decode u_decode (
        .WBs_CLK_i    (WBs_CLK_i),
        .FIFO_Flush   (FIFO_Flush),
        .req_i        (req_i),
        .ctrl_sts_i   (ctrl_sts),
        .dma_sts_i    (dma_sts),
        .ack_o        (ack_o),
        .reg_wr_o     (reg_wr),
        .pop_o        (pop),
        .reg_rd_o     (reg_rd_o),
        .dma_reg_rd_o (dma_reg_rd_o)
    );

    sensor_ctrl_regs u_ctrl (
        .WBs_CLK_i   (WBs_CLK_i),
        .FIFO_Flush  (FIFO_Flush),
        .reg_wr_i    (reg_wr),
        .overrun_i   (overrun),
        .sensor_en_o (sensor_en_o),
        .flush_o     (flush),
        .sts_o       (ctrl_sts)
    );

    dma_ctrl_regs #(
        .LEVEL_W         (LEVEL_W),
        .DMA_START_LEVEL (DMA_START_LEVEL)
    ) u_dma (
        .WBs_CLK_i   (WBs_CLK_i),
        .FIFO_Flush  (FIFO_Flush),
        .reg_wr_i    (reg_wr),
        .dma_done_i  (dma_done_i),
        .dma_clr_i   (dma_clr_i),
        .level_i     (level),
        .dma_en_o    (dma_en_o),
        .dma_start_o (dma_start_o),
        .dma_irq_o   (dma_irq_o),
        .sts_o       (dma_sts)
    );

    sensor_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .LEVEL_W    (LEVEL_W)
    ) u_fifo (
        .WBs_CLK_i   (WBs_CLK_i),
        .FIFO_Flush  (FIFO_Flush),
        .flush_i     (flush),
        .push_i      (sensor_push_i),
        .push_data_i (sensor_data_i),
        .pop_i       (pop),
        .pop_data_o  (dma_dat_o),
        .level_o     (level),
        .full_o      (fifo_full_o),
        .overrun_o   (overrun)
    );

endmodule

// ==== verif/sensor_dma_checker.sv ====
`timescale 1ns/1ps
module sensor_dma_checker (
    input logic WBs_CLK_i,
    input logic FIFO_Flush,
    input logic ack_i,
    input logic fifo_full_i,
    input logic dma_start_i,
    input logic dma_irq_i,
    input logic irq_en_i
);

    // Acknowledge is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge WBs_CLK_i) disable iff (FIFO_Flush)
        ack_i |=> !ack_i)
        else $error("acknowledge held for two cycles");

    no_flags_in_reset: assert property (@(posedge WBs_CLK_i)
        FIFO_Flush |-> (!fifo_full_i && !dma_start_i))
        else $error("full or start request high during reset");

    // Interrupt only with its enable set
    irq_needs_enable: assert property (@(posedge WBs_CLK_i) disable iff (FIFO_Flush)
        dma_irq_i |-> irq_en_i)
        else $error("interrupt high with interrupt enable low");

endmodule

bind sensor_dma_top sensor_dma_checker u_checker (
    .WBs_CLK_i   (WBs_CLK_i),
    .FIFO_Flush  (FIFO_Flush),
    .ack_i       (ack_o),
    .fifo_full_i (fifo_full_o),
    .dma_start_i (dma_start_o),
    .dma_irq_i   (dma_irq_o),
    .irq_en_i    (dma_sts.irq_en)
);

// ==== verif/tb_sensor_dma.sv ====
`timescale 1ns/1ps
module tb_sensor_dma;

    localparam int CLK_PERIOD  = 40;
    localparam int FIFO_DEPTH  = 16;
    localparam int START_LEVEL = 7;
    localparam int ACK_LIMIT   = 8;  // Cycles to wait for an acknowledge

    logic                    WBs_CLK_i;
    logic                    FIFO_Flush;
    sensor_dma_pkg::wb_req_t req;
    logic                    ack;
    logic [31:0]             reg_rd;
    logic [31:0]             dma_reg_rd;
    logic [31:0]             dma_dat;
    logic [31:0]             sensor_data;
    logic                    sensor_push;
    logic                    dma_done;
    logic                    dma_clr;
    logic                    sensor_en;
    logic                    fifo_full;
    logic                    dma_en;
    logic                    dma_start;
    logic                    dma_irq;
    logic [31:0]             device_id;

    string       lines[$];
    logic [31:0] fifo_model[$];  // Words the FIFO should still hold
    logic        model_dma_en;
    logic [15:0] lfsr;
    logic        stim_ready;
    logic        load_ok;
    string       cur_test;
    int          n_tests;
    int          n_checks;
    int          n_errors;
    int          test_checks;
    int          test_errors;

    sensor_dma_top #(
        .FIFO_DEPTH      (FIFO_DEPTH),
        .DMA_START_LEVEL (START_LEVEL)
    ) u_dut (
        .WBs_CLK_i     (WBs_CLK_i),
        .FIFO_Flush    (FIFO_Flush),
        .req_i         (req),
        .ack_o         (ack),
        .reg_rd_o      (reg_rd),
        .dma_reg_rd_o  (dma_reg_rd),
        .dma_dat_o     (dma_dat),
        .sensor_data_i (sensor_data),
        .sensor_push_i (sensor_push),
        .dma_done_i    (dma_done),
        .dma_clr_i     (dma_clr),
        .sensor_en_o   (sensor_en),
        .fifo_full_o   (fifo_full),
        .dma_en_o      (dma_en),
        .dma_start_o   (dma_start),
        .dma_irq_o     (dma_irq),
        .device_id_o   (device_id)
    );

    always #(CLK_PERIOD / 2) WBs_CLK_i = ~WBs_CLK_i;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++)
        begin
            w    = {w[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return w;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        n_checks++;
        test_checks++;
        assert (act_val === exp_val)
        else
        begin
            $display("FAILED %s (%s): expected %h, actual %h", cur_test, what, exp_val, act_val);
            n_errors++;
            test_errors++;
        end
    endtask

    task automatic note_problem(input logic ok, input string msg);
        assert (ok)
        else
        begin
            $display("Test %s: %s", cur_test, msg);
            n_errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test();
        if (cur_test != "")
        begin
            $display("Test %s done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
            n_tests++;
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic bus_access(input string bank, input logic [9:0] addr, input logic we,
                              input logic [31:0] wdata, input logic [3:0] be,
                              output logic [31:0] rdata, output logic ok);
        int waited;
        waited = 0;
        ok     = 1'b0;
        rdata  = '0;
        @(negedge WBs_CLK_i);
        req.adr         = addr[9:2];
        req.cyc_regs    = (bank == "regs");
        req.cyc_dma_reg = (bank == "dmareg");
        req.cyc_dma_dat = (bank == "dmadat");
        req.stb         = 1'b1;
        req.we          = we;
        req.byte_stb    = be;
        req.dat         = wdata;
        while (!ok && waited < ACK_LIMIT)
        begin
            @(negedge WBs_CLK_i);
            waited++;
            if (ack)
            begin
                ok    = 1'b1;
                rdata = req.cyc_regs ? reg_rd : (req.cyc_dma_reg ? dma_reg_rd : dma_dat);
            end
        end
        req = '0;  // Strobe drops after the acknowledge
        note_problem(ok, "no acknowledge from the DUT");
    endtask

    task automatic push_words(input int count);
        logic [31:0] word;
        repeat (count)
        begin
            word = random_word();
            @(negedge WBs_CLK_i);
            sensor_push = 1'b1;
            sensor_data = word;
            @(negedge WBs_CLK_i);
            sensor_push = 1'b0;
            if (fifo_model.size() < FIFO_DEPTH)
                fifo_model.push_back(word);  // Dropped when full
            check_value("dma_start_o", 32'(model_dma_en && fifo_model.size() > START_LEVEL),
                        {31'b0, dma_start});
        end
    endtask

    task automatic read_fifo(input int count);
        logic [31:0] rdata;
        logic        ok;
        repeat (count)
        begin
            bus_access("dmadat", 10'h000, 1'b0, '0, 4'hF, rdata, ok);
            // Empty FIFO shows a stale head word
            if (ok && fifo_model.size() > 0)
                check_value("fifo data", fifo_model.pop_front(), rdata);
        end
    endtask

    task automatic check_pin(input string name, input logic [31:0] exp_val);
        logic val;
        logic known;
        @(negedge WBs_CLK_i);
        known = 1'b1;
        val   = 1'b0;
        if (name == "sensor_en")
            val = sensor_en;
        else if (name == "fifo_full")
            val = fifo_full;
        else if (name == "dma_en")
            val = dma_en;
        else if (name == "dma_start")
            val = dma_start;
        else if (name == "dma_irq")
            val = dma_irq;
        else
            known = 1'b0;
        if (known)
            check_value(name, exp_val, {31'b0, val});
        else
            note_problem(1'b0, {"unknown output name ", name});
    endtask

    task automatic run_command(input string line);
        string       op;
        string       bank;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp_val;
        logic [31:0] rdata;
        logic        ok;
        int          n;
        n = $sscanf(line, "%s %s %h %h %h", op, bank, addr, data, exp_val);
        if (n != 5)
            note_problem(1'b0, {"malformed stimulus line ", line});
        else if (op == "test")
        begin
            finish_test();
            cur_test = bank;
        end
        else if (op == "write")
        begin
            bus_access(bank, addr[9:0], 1'b1, data, exp_val[3:0], rdata, ok);
            if (exp_val[0] && bank == "regs" && addr == 32'h008 && data[0])
                fifo_model.delete();  // Software flush
            if (exp_val[0] && bank == "dmareg" && addr == 32'h000)
                model_dma_en = data[0];
        end
        else if (op == "read" && bank == "dmadat")
            read_fifo(data);
        else if (op == "read")
        begin
            bus_access(bank, addr[9:0], 1'b0, '0, 4'hF, rdata, ok);
            if (ok)
                check_value($sformatf("read %s %h", bank, addr[9:0]), exp_val, rdata);
            // ID pin carries the same value as the ID register
            if (bank == "regs" && addr[9:0] == 10'h000)
                check_value("device_id_o", exp_val, device_id);
        end
        else if (op == "push")
            push_words(data);
        else if (op == "dma_done" || op == "dma_clr")
        begin
            @(negedge WBs_CLK_i);
            dma_done = (op == "dma_done");
            dma_clr  = (op == "dma_clr");
            @(negedge WBs_CLK_i);
            dma_done = 1'b0;
            dma_clr  = 1'b0;
            if (op == "dma_clr")
                model_dma_en = 1'b0;
        end
        else if (op == "pin")
            check_pin(bank, exp_val);
        else
            note_problem(1'b0, {"unknown operation ", op});
    endtask

    task automatic load_stimulus(output logic ok);
        int    fd;
        string line;
        fd = $fopen("verif/sensor_dma_stimulus.txt", "r");
        ok = (fd != 0);
        if (ok)
        begin
            while ($fgets(line, fd) > 0)
            begin
                if (line.len() > 1 && line.getc(0) != "#")
                    lines.push_back(line);
            end
            $fclose(fd);
        end
    endtask

    // Watchdog sized from the number of commands
    initial
    begin
        wait (stim_ready === 1'b1);
        #(CLK_PERIOD * 20 * lines.size());
        $display("Run timed out before all %0d stimulus lines finished", lines.size());
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        WBs_CLK_i    = 1'b0;
        FIFO_Flush   = 1'b1;
        req          = '0;
        sensor_data  = '0;
        sensor_push  = 1'b0;
        dma_done     = 1'b0;
        dma_clr      = 1'b0;
        model_dma_en = 1'b0;
        lfsr         = 16'd50494;
        stim_ready   = 1'b0;
        cur_test     = "";
        n_tests      = 0;
        n_checks     = 0;
        n_errors     = 0;
        test_checks  = 0;
        test_errors  = 0;
        load_stimulus(load_ok);
        if (!load_ok)
        begin
            $display("Could not open verif/sensor_dma_stimulus.txt");
            $display("CHECKS FAILED");
            $finish;
        end
        else
        begin
            stim_ready = 1'b1;
            repeat (8) @(posedge WBs_CLK_i);
            @(negedge WBs_CLK_i);
            FIFO_Flush = 1'b0;
            foreach (lines[i])
                run_command(lines[i]);
            finish_test();
            $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
            if (n_errors == 0)
                $display("ALL CHECKS PASSED");
            else
                $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

// ==== verif/sensor_dma_stimulus.txt ====
# op bank addr data expected, with addr, data and expected in hex
# write: expected holds the byte strobes; push and dmadat read: data is a word count
test fixed_reads 0 0 0
read regs 000 0 0ADC0001
read regs 004 0 00000100
read regs 008 0 00000000
read regs 3FC 0 FABDEFAC
read dmareg 0FC 0 FABDEFAC
test sensor_enable 0 0 0
write regs 00C 1 F
pin sensor_en 0 0 1
read regs 00C 0 00000001
write regs 00C 0 E
pin sensor_en 0 0 1
read regs 00C 0 00000001
test fifo_order 0 0 0
push - 0 A 0
read dmadat 000 A 0
read dmadat 000 1 0
push - 0 2 0
read dmadat 000 2 0
test dma_start 0 0 0
write dmareg 000 1 F
pin dma_en 0 0 1
push - 0 8 0
pin dma_start 0 0 1
read dmadat 000 1 0
pin dma_start 0 0 0
push - 0 1 0
dma_clr - 0 0 0
pin dma_en 0 0 0
pin dma_start 0 0 0
read dmareg 000 0 00000000
read dmadat 000 8 0
test overrun 0 0 0
push - 0 10 0
pin fifo_full 0 0 1
push - 0 3 0
pin fifo_full 0 0 1
read regs 010 0 00030001
write regs 008 1 F
pin fifo_full 0 0 0
read regs 010 0 00000000
push - 0 1 0
read dmadat 000 1 0
test done_irq 0 0 0
dma_done - 0 0 0
read dmareg 004 0 00000001
pin dma_irq 0 0 0
write dmareg 008 1 F
pin dma_irq 0 0 1
read dmareg 008 0 00000001
write dmareg 004 0 F
pin dma_irq 0 0 0
read dmareg 004 0 00000000

// ==== sources.f ====
rtl/sensor_dma_pkg.sv
rtl/wb_reg_decode.sv
rtl/sensor_ctrl_regs.sv
rtl/dma_ctrl_regs.sv
rtl/sensor_fifo.sv
rtl/sensor_dma_top.sv
verif/sensor_dma_checker.sv
verif/tb_sensor_dma.sv

// ==== Bender.yml ====
package:
  name: sensor_dma

sources:
  - files:
      - rtl/sensor_dma_pkg.sv
      - rtl/wb_reg_decode.sv
      - rtl/sensor_ctrl_regs.sv
      - rtl/dma_ctrl_regs.sv
      - rtl/sensor_fifo.sv
      - rtl/sensor_dma_top.sv
  - target: test
    files:
      - verif/sensor_dma_checker.sv
      - verif/tb_sensor_dma.sv
